// ==== build.f ====
verilog/fft_pkg.sv
verilog/bfly_sum_path.sv
verilog/bfly_diff_path.sv
verilog/twiddle_rotator.sv
verilog/fft_stage_top.sv
sim/fft_stage_chk.sv
sim/fft_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the FFT stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module fft_stage_tb \
    -Mdir obj_dir -o fft_stage_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/fft_stage_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" "$LOG"; then
    echo "test failed"
    exit 1
fi
echo "test passed"
exit 0

// ==== sim/fft_stage_chk.sv ====
module fft_stage_chk import fft_pkg::*; (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    valid_i,
    input  logic                    valid_o,
    input  logic signed [OUT_W-1:0] out_re_o [NLANES],
    input  logic signed [OUT_W-1:0] out_im_o [NLANES]
);

    // largest magnitude of a clamped pair rotated by a Q2.8 twiddle
    localparam int OUT_LIM = 2 * (SAT_MAX + 1);

    int assert_errors = 0;

    valid_low_in_reset: assert property (@(posedge clk) !rstn |-> !valid_o)
        else begin
            assert_errors++;
            $error("valid_o high while rstn is low");
        end

    valid_latency: assert property (@(posedge clk) disable iff (!rstn)
        valid_o == $past(valid_i, 3))
        else begin
            assert_errors++;
            $error("valid_o does not follow valid_i by 3 cycles");
        end

    for (genvar i = 0; i < NLANES; i++) begin : g_range
        re_in_range: assert property (@(posedge clk) disable iff (!rstn)
            int'(out_re_o[i]) >= -OUT_LIM && int'(out_re_o[i]) <= OUT_LIM)
            else begin
                assert_errors++;
                $error("out_re_o[%0d] outside full-scale range: %0d", i, out_re_o[i]);
            end
        im_in_range: assert property (@(posedge clk) disable iff (!rstn)
            int'(out_im_o[i]) >= -OUT_LIM && int'(out_im_o[i]) <= OUT_LIM)
            else begin
                assert_errors++;
                $error("out_im_o[%0d] outside full-scale range: %0d", i, out_im_o[i]);
            end
    end

endmodule

bind fft_stage_top fft_stage_chk u_chk (
    .clk      (clk),
    .rstn     (rstn),
    .valid_i  (valid_i),
    .valid_o  (valid_o),
    .out_re_o (out_re_o),
    .out_im_o (out_im_o)
);

// ==== sim/fft_stage_tb.sv ====
module fft_stage_tb import fft_pkg::*; ();

    localparam int N_RAND = 40;
    localparam int N_TW   = 20;
    localparam int N_SAT  = 8;
    localparam int N_GAP  = 30;
    localparam int TIMEOUT_CYC = 2 * (N_RAND + N_TW + N_SAT + N_GAP) + 50;

    typedef struct packed {
        int                     num;
        int                     stamp;  // cycle in which valid_i was high
        logic [NLANES*IN_W-1:0] re;
        logic [NLANES*IN_W-1:0] im;
    } beat_t;

    logic                    clk;
    logic                    rstn;
    logic                    valid_i;
    logic signed [IN_W-1:0]  in_re_i [NLANES];
    logic signed [IN_W-1:0]  in_im_i [NLANES];
    logic                    valid_o;
    logic signed [OUT_W-1:0] out_re_o [NLANES];
    logic signed [OUT_W-1:0] out_im_o [NLANES];

    beat_t                  exp_q [$];
    logic [NLANES*IN_W-1:0] stim_re;
    logic [NLANES*IN_W-1:0] stim_im;
    integer                 seed = 32'h29c3_1c31;
    int                     cyc = 0;
    int                     beat_num = 0;
    int                     checked = 0;
    int                     value_errors = 0;
    int                     other_errors = 0;

    fft_stage_top UUT (
        .clk      (clk),
        .rstn     (rstn),
        .valid_i  (valid_i),
        .in_re_i  (in_re_i),
        .in_im_i  (in_im_i),
        .valid_o  (valid_o),
        .out_re_o (out_re_o),
        .out_im_o (out_im_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    initial begin : watchdog
        while (cyc < TIMEOUT_CYC) @(posedge clk);
        $display("timeout: run still going after %0d cycles", TIMEOUT_CYC);
        $display("FAIL: see errors above");
        $finish;
    end

    function automatic int saturate(input int x);
        if (x > SAT_MAX)
            return SAT_MAX;
        if (x < SAT_MIN)
            return SAT_MIN;
        return x;
    endfunction

    // add half an lsb and floor
    function automatic int round_shift(input int x);
        return (x + RND_BIAS) >>> RND_SHIFT;
    endfunction

    function automatic void expected_lanes(
        input  logic [NLANES*IN_W-1:0] re,
        input  logic [NLANES*IN_W-1:0] im,
        input  logic [1:0]             tw,
        output int                     exp_re [NLANES],
        output int                     exp_im [NLANES]
    );
        int lo, hi;
        int xr, xi, yr, yi;
        int sr, si, dr, di;
        int swr, swi, dwr, dwi;
        swr = int'(TW_SUM_RE[tw]);
        swi = int'(TW_SUM_IM[tw]);
        dwr = int'(TW_DIF_RE[tw]);
        dwi = int'(TW_DIF_IM[tw]);
        for (int g = 0; g < NLANES/4; g++) begin
            for (int j = 0; j < 2; j++) begin
                lo = 4*g + j;
                hi = lo + 2;
                xr = int'($signed(re[lo*IN_W +: IN_W]));
                xi = int'($signed(im[lo*IN_W +: IN_W]));
                yr = int'($signed(re[hi*IN_W +: IN_W]));
                yi = int'($signed(im[hi*IN_W +: IN_W]));
                sr = saturate(xr + yr);
                si = saturate(xi + yi);
                dr = saturate(xr - yr);
                di = saturate(xi - yi);
                exp_re[lo] = round_shift(sr*swr - si*swi);
                exp_im[lo] = round_shift(si*swr + sr*swi);
                exp_re[hi] = round_shift(dr*dwr - di*dwi);
                exp_im[hi] = round_shift(di*dwr + dr*dwi);
            end
        end
    endfunction

    task automatic fill_random();
        int r;
        for (int i = 0; i < NLANES; i++) begin
            r = $random(seed);
            stim_re[i*IN_W +: IN_W] = r[IN_W-1:0];
            r = $random(seed);
            stim_im[i*IN_W +: IN_W] = r[IN_W-1:0];
        end
    endtask

    task automatic fill_fullscale(input int k);
        int r;
        bit top_re;
        bit top_im;
        for (int i = 0; i < NLANES; i++) begin
            r = $random(seed);
            case (k)
                0: top_re = 1'b1;             // sums clamp high
                1: top_re = 1'b0;
                2: top_re = (i % 4) < 2;      // differences clamp high
                3: top_re = (i % 4) >= 2;
                default: top_re = r[0];
            endcase
            top_im = (k < 4) ? top_re : r[1];
            stim_re[i*IN_W +: IN_W] = top_re ? IN_W'(SAT_MAX) : IN_W'(SAT_MIN);
            stim_im[i*IN_W +: IN_W] = top_im ? IN_W'(SAT_MAX) : IN_W'(SAT_MIN);
        end
    endtask

    task automatic drive_beat();
        beat_t b;
        @(posedge clk);
        valid_i <= 1'b1;
        for (int i = 0; i < NLANES; i++) begin
            in_re_i[i] <= stim_re[i*IN_W +: IN_W];
            in_im_i[i] <= stim_im[i*IN_W +: IN_W];
        end
        b.num   = beat_num;
        b.stamp = cyc + 1;  // cyc steps at this same edge
        b.re    = stim_re;
        b.im    = stim_im;
        exp_q.push_back(b);
        beat_num++;
    endtask

    task automatic drive_idle(input int n);
        repeat (n) begin
            @(posedge clk);
            valid_i <= 1'b0;
        end
    endtask

    task automatic check_quiet();
        assert (valid_o == 1'b0) else begin
            value_errors++;
            $display("FAILED time %0t valid_o expected 0 actual %0d", $time, valid_o);
        end
        for (int i = 0; i < NLANES; i++) begin
            assert (int'(out_re_o[i]) == 0 && int'(out_im_o[i]) == 0) else begin
                value_errors++;
                $display("FAILED time %0t out_re_o/out_im_o[%0d] expected 0/0 actual %0d/%0d",
                         $time, i, out_re_o[i], out_im_o[i]);
            end
        end
    endtask

    always @(negedge clk) begin : compare
        beat_t      b;
        int         exp_re [NLANES];
        int         exp_im [NLANES];
        logic [1:0] tw;
        if (rstn && valid_o) begin
            assert (exp_q.size() > 0) else begin
                other_errors++;
                $display("valid_o high at time %0t with no beat outstanding", $time);
            end
            if (exp_q.size() > 0) begin
                b  = exp_q.pop_front();
                tw = 2'((b.num % 16) / 4);
                expected_lanes(b.re, b.im, tw, exp_re, exp_im);
                assert (cyc - b.stamp == 3) else begin
                    other_errors++;
                    $display("beat %0d came out %0d cycles after its input instead of 3",
                             b.num, cyc - b.stamp);
                end
                for (int i = 0; i < NLANES; i++) begin
                    assert (int'(out_re_o[i]) == exp_re[i]) else begin
                        value_errors++;
                        $display("FAILED time %0t out_re_o[%0d] expected %0d actual %0d",
                                 $time, i, exp_re[i], out_re_o[i]);
                    end
                    assert (int'(out_im_o[i]) == exp_im[i]) else begin
                        value_errors++;
                        $display("FAILED time %0t out_im_o[%0d] expected %0d actual %0d",
                                 $time, i, exp_im[i], out_im_o[i]);
                    end
                end
                checked++;
            end
        end
    end

    initial begin
        int r;
        int chk_errors;
        rstn    <= 1'b0;
        valid_i <= 1'b0;
        for (int i = 0; i < NLANES; i++) begin
            in_re_i[i] <= '0;
            in_im_i[i] <= '0;
        end
        repeat (3) begin
            @(negedge clk);
            check_quiet();
        end
        @(posedge clk);
        rstn <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_quiet();
        end

        for (int n = 0; n < N_RAND; n++) begin  // back to back
            fill_random();
            drive_beat();
        end
        drive_idle(1);

        // lane pair 0 held fixed while the twiddle steps
        for (int n = 0; n < N_TW; n++) begin
            fill_random();
            stim_re[0 +: IN_W]      = IN_W'(1000);
            stim_im[0 +: IN_W]      = IN_W'(-700);
            stim_re[2*IN_W +: IN_W] = IN_W'(300);
            stim_im[2*IN_W +: IN_W] = IN_W'(450);
            drive_beat();
        end
        drive_idle(1);

        for (int k = 0; k < N_SAT; k++) begin
            fill_fullscale(k);
            drive_beat();
        end
        drive_idle(1);

        for (int n = 0; n < N_GAP; n++) begin
            r = $random(seed);
            drive_idle(int'(r[1:0]));
            fill_random();
            drive_beat();
        end
        drive_idle(1);

        for (int k = 0; k < 8 && exp_q.size() > 0; k++)
            @(posedge clk);
        assert (exp_q.size() == 0) else begin
            other_errors++;
            $display("%0d beats never came out of the DUT", exp_q.size());
        end

        chk_errors = UUT.u_chk.assert_errors;
        $display("closing: %0d beats checked, errors: %0d value, %0d other, %0d assertion",
                 checked, value_errors, other_errors, chk_errors);
        if (value_errors == 0 && other_errors == 0 && chk_errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== verilog/bfly_diff_path.sv ====
module bfly_diff_path import fft_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   valid_i,
    input  logic signed [IN_W-1:0] in_re_i [NLANES],
    input  logic signed [IN_W-1:0] in_im_i [NLANES],
    output logic signed [IN_W-1:0] dif_re_o [NLANES/2],
    output logic signed [IN_W-1:0] dif_im_o [NLANES/2]
);

    logic signed [SUM_W-1:0] raw_re [NLANES/2];
    logic signed [SUM_W-1:0] raw_im [NLANES/2];

    // opposite-sign full scale inputs overflow here, so clamp instead of wrap
    function automatic logic signed [IN_W-1:0] clamp(input logic signed [SUM_W-1:0] x);
        if (x > SUM_W'(SAT_MAX))
            return IN_W'(SAT_MAX);
        if (x < SUM_W'(SAT_MIN))
            return IN_W'(SAT_MIN);
        return x[IN_W-1:0];
    endfunction

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int p = 0; p < NLANES/2; p++) begin
                raw_re[p] <= '0;
                raw_im[p] <= '0;
            end
        end else if (valid_i) begin
            for (int g = 0; g < NLANES/4; g++) begin
                for (int j = 0; j < 2; j++) begin
                    // lower lane minus upper lane
                    raw_re[2*g+j] <= SUM_W'(in_re_i[4*g+j]) - SUM_W'(in_re_i[4*g+j+2]);
                    raw_im[2*g+j] <= SUM_W'(in_im_i[4*g+j]) - SUM_W'(in_im_i[4*g+j+2]);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int p = 0; p < NLANES/2; p++) begin
                dif_re_o[p] <= '0;
                dif_im_o[p] <= '0;
            end
        end else begin
            for (int p = 0; p < NLANES/2; p++) begin
                dif_re_o[p] <= clamp(raw_re[p]);
                dif_im_o[p] <= clamp(raw_im[p]);
            end
        end
    end

endmodule

// ==== verilog/bfly_sum_path.sv ====
module bfly_sum_path import fft_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   valid_i,
    input  logic signed [IN_W-1:0] in_re_i [NLANES],
    input  logic signed [IN_W-1:0] in_im_i [NLANES],
    output logic signed [IN_W-1:0] sum_re_o [NLANES/2],
    output logic signed [IN_W-1:0] sum_im_o [NLANES/2]
);

    logic signed [SUM_W-1:0] raw_re [NLANES/2];
    logic signed [SUM_W-1:0] raw_im [NLANES/2];

    function automatic logic signed [IN_W-1:0] clamp(input logic signed [SUM_W-1:0] x);
        if (x > SUM_W'(SAT_MAX))
            return IN_W'(SAT_MAX);
        if (x < SUM_W'(SAT_MIN))
            return IN_W'(SAT_MIN);
        return x[IN_W-1:0];
    endfunction

    // raw sums, taken only on valid beats
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int p = 0; p < NLANES/2; p++) begin
                raw_re[p] <= '0;
                raw_im[p] <= '0;
            end
        end else if (valid_i) begin
            for (int g = 0; g < NLANES/4; g++) begin
                for (int j = 0; j < 2; j++) begin
                    raw_re[2*g+j] <= SUM_W'(in_re_i[4*g+j]) + SUM_W'(in_re_i[4*g+j+2]);
                    raw_im[2*g+j] <= SUM_W'(in_im_i[4*g+j]) + SUM_W'(in_im_i[4*g+j+2]);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int p = 0; p < NLANES/2; p++) begin
                sum_re_o[p] <= '0;
                sum_im_o[p] <= '0;
            end
        end else begin
            for (int p = 0; p < NLANES/2; p++) begin
                sum_re_o[p] <= clamp(raw_re[p]);
                sum_im_o[p] <= clamp(raw_im[p]);
            end
        end
    end

endmodule

// ==== verilog/fft_pkg.sv ====
package fft_pkg;

    localparam int NLANES = 16;     // complex lanes per beat
    localparam int IN_W   = 14;
    localparam int SUM_W  = 15;     // one growth bit for sum or difference
    localparam int OUT_W  = 16;
    localparam int TW_W   = 10;     // Q2.8, 256 is 1.0
    localparam int PROD_W = 24;

    // clamp range of the 14-bit sample
    localparam int SAT_MAX = 8191;
    localparam int SAT_MIN = -8192;

    localparam int RND_SHIFT = 8;
    localparam int RND_BIAS  = 128;  // half an lsb of the shifted result

    // twiddle pairs, indexed by beat count / 4
    localparam logic signed [TW_W-1:0] TW_SUM_RE [4] = '{
        10'sd256, 10'sd256, 10'sd256, 10'sd181
    };
    localparam logic signed [TW_W-1:0] TW_SUM_IM [4] = '{
        10'sd256, 10'sd0, 10'sd256, -10'sd181
    };
    localparam logic signed [TW_W-1:0] TW_DIF_RE [4] = '{
        10'sd0, 10'sd0, 10'sd0, -10'sd181
    };
    localparam logic signed [TW_W-1:0] TW_DIF_IM [4] = '{
        10'sd0, -10'sd256, 10'sd0, -10'sd181
    };

endpackage

// ==== verilog/fft_stage_top.sv ====
module fft_stage_top import fft_pkg::*; (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    valid_i,
    input  logic signed [IN_W-1:0]  in_re_i [NLANES],
    input  logic signed [IN_W-1:0]  in_im_i [NLANES],
    output logic                    valid_o,
    output logic signed [OUT_W-1:0] out_re_o [NLANES],
    output logic signed [OUT_W-1:0] out_im_o [NLANES]
);

    // saturated pair results, one entry per lane pair
    logic signed [IN_W-1:0] sum_re [NLANES/2];
    logic signed [IN_W-1:0] sum_im [NLANES/2];
    logic signed [IN_W-1:0] dif_re [NLANES/2];
    logic signed [IN_W-1:0] dif_im [NLANES/2];

    bfly_sum_path u_sum (
        .clk      (clk),
        .rstn     (rstn),
        .valid_i  (valid_i),
        .in_re_i  (in_re_i),
        .in_im_i  (in_im_i),
        .sum_re_o (sum_re),
        .sum_im_o (sum_im)
    );

    bfly_diff_path u_diff (
        .clk      (clk),
        .rstn     (rstn),
        .valid_i  (valid_i),
        .in_re_i  (in_re_i),
        .in_im_i  (in_im_i),
        .dif_re_o (dif_re),
        .dif_im_o (dif_im)
    );

    // valid_i is delayed inside the rotator to meet the path outputs
    twiddle_rotator u_rot (
        .clk      (clk),
        .rstn     (rstn),
        .valid_i  (valid_i),
        .sum_re_i (sum_re),
        .sum_im_i (sum_im),
        .dif_re_i (dif_re),
        .dif_im_i (dif_im),
        .valid_o  (valid_o),
        .out_re_o (out_re_o),
        .out_im_o (out_im_o)
    );

endmodule

// ==== verilog/twiddle_rotator.sv ====
module twiddle_rotator import fft_pkg::*; (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    valid_i,
    input  logic signed [IN_W-1:0]  sum_re_i [NLANES/2],
    input  logic signed [IN_W-1:0]  sum_im_i [NLANES/2],
    input  logic signed [IN_W-1:0]  dif_re_i [NLANES/2],
    input  logic signed [IN_W-1:0]  dif_im_i [NLANES/2],
    output logic                    valid_o,
    output logic signed [OUT_W-1:0] out_re_o [NLANES],
    output logic signed [OUT_W-1:0] out_im_o [NLANES]
);

    logic             valid_d1;
    logic             valid_d2;   // lines up with the saturated path outputs
    logic [3:0]       beat_cnt;
    logic [1:0]       tw_idx;

    logic signed [TW_W-1:0] sum_wr;
    logic signed [TW_W-1:0] sum_wi;
    logic signed [TW_W-1:0] dif_wr;
    logic signed [TW_W-1:0] dif_wi;

    logic signed [OUT_W-1:0] rot_re [NLANES];
    logic signed [OUT_W-1:0] rot_im [NLANES];

    // (a + jb)(wr + jwi), real part
    function automatic logic signed [PROD_W-1:0] cmul_re(
        input logic signed [IN_W-1:0] a,
        input logic signed [IN_W-1:0] b,
        input logic signed [TW_W-1:0] wr,
        input logic signed [TW_W-1:0] wi
    );
        return PROD_W'(a) * PROD_W'(wr) - PROD_W'(b) * PROD_W'(wi);
    endfunction

    function automatic logic signed [PROD_W-1:0] cmul_im(
        input logic signed [IN_W-1:0] a,
        input logic signed [IN_W-1:0] b,
        input logic signed [TW_W-1:0] wr,
        input logic signed [TW_W-1:0] wi
    );
        return PROD_W'(b) * PROD_W'(wr) + PROD_W'(a) * PROD_W'(wi);
    endfunction

    function automatic logic signed [OUT_W-1:0] round_prod(input logic signed [PROD_W-1:0] x);
        logic signed [PROD_W-1:0] y;
        y = (x + PROD_W'(RND_BIAS)) >>> RND_SHIFT;
        return y[OUT_W-1:0];
    endfunction

    assign tw_idx = beat_cnt[3:2];  // four beats per twiddle pair
    assign sum_wr = TW_SUM_RE[tw_idx];
    assign sum_wi = TW_SUM_IM[tw_idx];
    assign dif_wr = TW_DIF_RE[tw_idx];
    assign dif_wi = TW_DIF_IM[tw_idx];

    // sum goes to lane 4g+j, difference to lane 4g+j+2
    always_comb begin
        for (int g = 0; g < NLANES/4; g++) begin
            for (int j = 0; j < 2; j++) begin
                rot_re[4*g+j]   = round_prod(cmul_re(sum_re_i[2*g+j], sum_im_i[2*g+j],
                                                     sum_wr, sum_wi));
                rot_im[4*g+j]   = round_prod(cmul_im(sum_re_i[2*g+j], sum_im_i[2*g+j],
                                                     sum_wr, sum_wi));
                rot_re[4*g+j+2] = round_prod(cmul_re(dif_re_i[2*g+j], dif_im_i[2*g+j],
                                                     dif_wr, dif_wi));
                rot_im[4*g+j+2] = round_prod(cmul_im(dif_re_i[2*g+j], dif_im_i[2*g+j],
                                                     dif_wr, dif_wi));
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_d1 <= 1'b0;
            valid_d2 <= 1'b0;
            valid_o  <= 1'b0;
            beat_cnt <= '0;
            for (int i = 0; i < NLANES; i++) begin
                out_re_o[i] <= '0;
                out_im_o[i] <= '0;
            end
        end else begin
            valid_d1 <= valid_i;
            valid_d2 <= valid_d1;
            valid_o  <= valid_d2;
            if (valid_d2) begin
                beat_cnt <= beat_cnt + 4'd1;  // wraps after 16 output beats
                for (int i = 0; i < NLANES; i++) begin
                    out_re_o[i] <= rot_re[i];
                    out_im_o[i] <= rot_im[i];
                end
            end
        end
    end

endmodule
